// File: rxd_pkg.sv
// Shared types and constants for the RRD/RLD nibble-rotate subsystem
// Step numbers follow the XPT timing of the instruction, steps 0 to 3 are fetch
package rxd_pkg;

    // ******************************************************************
    // Vector types
    // ******************************************************************

    typedef logic [4:0]  step_t;   // XPT timing step
    typedef logic [7:0]  byte_t;   // Data, accumulator, opcode
    typedef logic [15:0] addr_t;   // HL memory address
    typedef logic [7:0]  flags_t;  // F register

    // ******************************************************************
    // Flag bit positions
    // ******************************************************************

    localparam int FLAG_S  = 7;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_H  = 4;
    localparam int FLAG_PV = 2;
    localparam int FLAG_N  = 1;
    localparam int FLAG_C  = 0;

    // ******************************************************************
    // Step numbers
    // ******************************************************************

    localparam step_t STEP_FIRST = 5'd4;   // First memory read step
    localparam step_t STEP_CALC  = 5'd7;   // Rotate and flag write
    localparam step_t STEP_LAST  = 5'd13;  // Last memory write step

    // Run control
    typedef enum logic [1:0] {
        IDLE,
        ARM,
        RUN
    } seq_state_t;

endpackage

// File: rxd_ctrl_if.sv
// Per-step control strobes from the step decoder to the data modules
// All strobes are levels that hold for one whole XPT step, no handshake
`timescale 1ns/1ps

interface rxd_ctrl_if;

    logic rd_step;       // Steps 4 to 6
    logic wr_step;       // Steps 11 to 13
    logic dt_write;      // Steps 6 and 7
    logic calc;          // Step 7
    logic rotate_left;   // Step 7, RLD
    logic rotate_right;  // Step 7, RRD
    logic last_step;     // Step 13
    logic addr_hl;       // HL on the address bus

    // Decoder side
    modport dec (
        output rd_step,
        output wr_step,
        output dt_write,
        output calc,
        output rotate_left,
        output rotate_right,
        output last_step,
        output addr_hl
    );

    // Memory port and ALU side
    modport sink (
        input rd_step,
        input wr_step,
        input dt_write,
        input calc,
        input rotate_left,
        input rotate_right,
        input last_step,
        input addr_hl
    );

endinterface

// File: rxd_seq_fsm.sv
// Run control for one RRD/RLD instruction, start is ignored while busy
`timescale 1ns/1ps

module rxd_seq_fsm import rxd_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  byte_t opcode,
    input  logic  last_step,
    output logic  arm,
    output logic  busy,
    output logic  done,
    output logic  rld_mode
);

    seq_state_t state_q, state_d;
    logic       done_q;
    logic       rld_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start) state_d = ARM;
            ARM:     state_d = RUN;           // One cycle to load XPT
            RUN:     if (last_step) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
            rld_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == RUN) && last_step;
            if (state_q == IDLE && start)
                rld_q <= opcode[3];           // 0x67 RRD, 0x6F RLD
        end
    end

    assign arm      = (state_q == ARM);
    assign busy     = (state_q != IDLE);
    assign done     = done_q;
    assign rld_mode = rld_q;

    // Step 13 only arrives inside a run
    assert property (@(posedge clk) disable iff (!arst_n)
        last_step |-> state_q == RUN);

    // Ten steps between arming and done
    assert property (@(posedge clk) disable iff (!arst_n)
        done |-> $past(state_q == ARM, 11));

endmodule

// File: rxd_step_counter.sv
// XPT step counter, walks steps 4 to 13 once per arm
// Depends on the decoder returning last_step at step 13
`timescale 1ns/1ps

module rxd_step_counter import rxd_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  arm,
    input  logic  last_step,
    output step_t xpt,
    output logic  xpt_valid
);

    step_t xpt_q;
    logic  valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xpt_q   <= '0;
            valid_q <= 1'b0;
        end else if (arm) begin
            xpt_q   <= STEP_FIRST;
            valid_q <= 1'b1;
        end else if (last_step) begin
            xpt_q   <= '0;                    // Reset XPT
            valid_q <= 1'b0;
        end else if (valid_q) begin
            xpt_q   <= xpt_q + 5'd1;
        end
    end

    assign xpt       = xpt_q;
    assign xpt_valid = valid_q;

    // ******************************************************************
    // Checks
    // ******************************************************************

    assert property (@(posedge clk) disable iff (!arst_n)
        valid_q |-> xpt_q >= STEP_FIRST && xpt_q <= STEP_LAST);

    // The decoder must end the run exactly at the last step
    assert property (@(posedge clk) disable iff (!arst_n)
        valid_q && xpt_q == STEP_LAST |-> last_step);

endmodule

// File: rxd_step_decoder.sv
// Combinational XPT decoder for RRD/RLD, opcode bit 3 selects the direction
// Steps 8 to 10 and invalid steps raise no strobe
`timescale 1ns/1ps

module rxd_step_decoder import rxd_pkg::*; (
    input  step_t          xpt,
    input  logic           xpt_valid,
    input  logic           rld_mode,
    rxd_ctrl_if.dec        ctrl
);

    logic enable;
    logic t01xx;
    logic t10xx;
    logic t11xx;
    logic t4, t5, t6, t7;
    logic t11, t12, t13;

    assign enable = xpt_valid && !xpt[4];

    // ******************************************************************
    // Group decode on XPT[3:2]
    // ******************************************************************

    assign t01xx = enable && (xpt[3:2] == 2'b01);   // 4 to 7
    assign t10xx = enable && (xpt[3:2] == 2'b10);   // 8 to 11
    assign t11xx = enable && (xpt[3:2] == 2'b11);   // 12 to 15

    // Low bits within each group
    assign t4  = t01xx && (xpt[1:0] == 2'b00);
    assign t5  = t01xx && (xpt[1:0] == 2'b01);
    assign t6  = t01xx && (xpt[1:0] == 2'b10);
    assign t7  = t01xx && (xpt[1:0] == 2'b11);
    assign t11 = t10xx && (xpt[1:0] == 2'b11);
    assign t12 = t11xx && (xpt[1:0] == 2'b00);
    assign t13 = t11xx && (xpt[1:0] == 2'b01);

    // ******************************************************************
    // Strobes
    // ******************************************************************

    assign ctrl.rd_step      = t4 || t5 || t6;
    assign ctrl.wr_step      = t11 || t12 || t13;
    assign ctrl.dt_write     = t01xx && xpt[1];     // 6 or 7
    assign ctrl.calc         = t7;
    assign ctrl.rotate_left  = t7 && rld_mode;
    assign ctrl.rotate_right = t7 && !rld_mode;
    assign ctrl.last_step    = t13;
    assign ctrl.addr_hl      = (t4 || t5 || t6) || (t11 || t12 || t13);

endmodule

// File: rxd_mem_port.sv
// Memory bus for the HL read and write cycles, plus the Dt data latch
// Memory must return read data one cycle after the address and hold it to step 6
`timescale 1ns/1ps

module rxd_mem_port import rxd_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    rxd_ctrl_if.sink ctrl,
    input  addr_t    hl_addr,
    input  byte_t    mem_rdata,
    input  byte_t    rotated,
    output logic     mem_rd,
    output logic     mem_wr,
    output addr_t    mem_addr,
    output byte_t    mem_wdata,
    output byte_t    dt
);

    byte_t dt_q;

    // ******************************************************************
    // Bus strobes and address
    // ******************************************************************

    assign mem_rd    = ctrl.rd_step;                  // Steps 4 to 6
    assign mem_wr    = ctrl.wr_step;                  // Steps 11 to 13
    assign mem_addr  = ctrl.addr_hl ? hl_addr : '0;
    assign mem_wdata = dt_q;

    // ******************************************************************
    // Dt latch
    // ******************************************************************

    // Step 6 takes the memory byte, step 7 the rotated result
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dt_q <= '0;
        end else if (ctrl.dt_write) begin
            if (ctrl.calc)
                dt_q <= rotated;
            else
                dt_q <= mem_rdata;
        end
    end

    assign dt = dt_q;

    // Memory data is only taken after a read cycle has been on the bus
    assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.dt_write && !ctrl.calc |-> $past(mem_rd) && mem_rd);

    // Write data is stable for the whole write cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr && $past(mem_wr) |-> mem_wdata == $past(mem_wdata));

endmodule

// File: rxd_nibble_alu.sv
// Accumulator, flag register and nibble rotate for RRD/RLD
// Carry is held, bits 5 and 3 of F are left as they are
`timescale 1ns/1ps

module rxd_nibble_alu import rxd_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    rxd_ctrl_if.sink ctrl,
    input  byte_t    dt,
    input  logic     a_load,
    input  byte_t    a_load_value,
    output byte_t    rotated,
    output byte_t    a_out,
    output flags_t   flags_out
);

    byte_t  a_q;
    flags_t flags_q;
    byte_t  new_a;
    flags_t flags_d;

    // ******************************************************************
    // Rotate
    // ******************************************************************

    always_comb begin
        new_a   = a_q;
        rotated = dt;
        if (ctrl.rotate_right) begin
            new_a   = {a_q[7:4], dt[3:0]};
            rotated = {a_q[3:0], dt[7:4]};    // A low into M high
        end else if (ctrl.rotate_left) begin
            new_a   = {a_q[7:4], dt[7:4]};
            rotated = {dt[3:0], a_q[3:0]};    // M low up, A low in
        end
    end

    always_comb begin
        flags_d          = flags_q;
        flags_d[FLAG_S]  = new_a[7];
        flags_d[FLAG_Z]  = (new_a == 8'h00);
        flags_d[FLAG_PV] = ~^new_a;           // Even parity
        flags_d[FLAG_H]  = 1'b0;
        flags_d[FLAG_N]  = 1'b0;
    end

    // ******************************************************************
    // Registers
    // ******************************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q     <= '0;
            flags_q <= '0;
        end else if (ctrl.calc) begin
            a_q     <= new_a;
            flags_q <= flags_d;
        end else if (a_load) begin
            a_q     <= a_load_value;
        end
    end

    assign a_out     = a_q;
    assign flags_out = flags_q;

    // Every calc step carries exactly one rotate direction
    assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.calc |-> $onehot({ctrl.rotate_left, ctrl.rotate_right}));

endmodule

// File: rxd_top.sv
// RRD/RLD execution unit, one instruction per start pulse
// hl_addr must stay stable from start until done
`timescale 1ns/1ps

module rxd_top import rxd_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    input  byte_t  opcode,
    input  addr_t  hl_addr,
    input  logic   a_load,
    input  byte_t  a_load_value,
    input  byte_t  mem_rdata,
    output logic   mem_rd,
    output logic   mem_wr,
    output addr_t  mem_addr,
    output byte_t  mem_wdata,
    output byte_t  a_out,
    output flags_t flags_out,
    output logic   busy,
    output logic   done
);

    logic  arm;
    logic  rld_mode;
    step_t xpt;
    logic  xpt_valid;
    byte_t dt;
    byte_t rotated;
    logic  a_load_idle;

    rxd_ctrl_if u_ctrl ();

    assign a_load_idle = a_load && !busy;     // No load during a run

    // ******************************************************************
    // Control path
    // ******************************************************************

    rxd_seq_fsm u_seq_fsm (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .opcode    (opcode),
        .last_step (u_ctrl.last_step),
        .arm       (arm),
        .busy      (busy),
        .done      (done),
        .rld_mode  (rld_mode)
    );

    rxd_step_counter u_step_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .arm       (arm),
        .last_step (u_ctrl.last_step),
        .xpt       (xpt),
        .xpt_valid (xpt_valid)
    );

    rxd_step_decoder u_step_decoder (
        .xpt       (xpt),
        .xpt_valid (xpt_valid),
        .rld_mode  (rld_mode),
        .ctrl      (u_ctrl.dec)
    );

    // ******************************************************************
    // Data path
    // ******************************************************************

    rxd_mem_port u_mem_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (u_ctrl.sink),
        .hl_addr   (hl_addr),
        .mem_rdata (mem_rdata),
        .rotated   (rotated),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .dt        (dt)
    );

    rxd_nibble_alu u_nibble_alu (
        .clk          (clk),
        .arst_n       (arst_n),
        .ctrl         (u_ctrl.sink),
        .dt           (dt),
        .a_load       (a_load_idle),
        .a_load_value (a_load_value),
        .rotated      (rotated),
        .a_out        (a_out),
        .flags_out    (flags_out)
    );

endmodule

// File: rxd_tb.sv
// Random RRD/RLD runs on rxd_top, checked against a nibble model
// Memory model holds 256 bytes, only the low byte of HL selects an entry
`timescale 1ns/1ps

module rxd_tb import rxd_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RUNS_PER_OP  = 100;
    localparam int N_TESTS      = 2 * RUNS_PER_OP + 1;
    localparam int WATCH_CYCLES = N_TESTS * 20 + 100;
    localparam int DONE_CYCLE   = 12;               // Start pulse to done

    logic   clk = 1'b0;
    logic   arst_n;
    logic   start;
    byte_t  opcode;
    addr_t  hl_addr;
    logic   a_load;
    byte_t  a_load_value;
    byte_t  mem_rdata = 8'h00;
    logic   mem_rd;
    logic   mem_wr;
    addr_t  mem_addr;
    byte_t  mem_wdata;
    byte_t  a_out;
    flags_t flags_out;
    logic   busy;
    logic   done;

    byte_t       mem [0:255];
    logic        load_req;
    logic [7:0]  load_addr;
    byte_t       load_data;
    logic [31:0] lfsr = 32'h14f4;
    flags_t      model_flags;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    rxd_top u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .opcode       (opcode),
        .hl_addr      (hl_addr),
        .a_load       (a_load),
        .a_load_value (a_load_value),
        .mem_rdata    (mem_rdata),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .a_out        (a_out),
        .flags_out    (flags_out),
        .busy         (busy),
        .done         (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ******************************************************************
    // Memory model
    // ******************************************************************

    always @(posedge clk) begin
        if (mem_rd)
            mem_rdata <= mem[mem_addr[7:0]];         // One cycle after address
        if (mem_wr)
            mem[mem_addr[7:0]] <= mem_wdata;         // Last edge of mem_wr wins
        if (load_req)
            mem[load_addr] <= load_data;             // Preload before a run
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic even_parity(input byte_t v);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++)
            ones += int'(v[i]);
        return (ones % 2) == 0;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [15:0] exp, input logic [15:0] act);
        $display("MISMATCH %s %s expected %0h actual %0h", name, what, exp, act);
        test_errors++;
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s ok", name);
        end else begin
            fail_count++;
            $display("test %s FAILED with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic check_reset();
        if (busy !== 1'b0)
            report_mismatch("reset_state", "busy", 16'd0, 16'(busy));
        if (done !== 1'b0)
            report_mismatch("reset_state", "done", 16'd0, 16'(done));
        if (mem_rd !== 1'b0)
            report_mismatch("reset_state", "mem_rd", 16'd0, 16'(mem_rd));
        if (mem_wr !== 1'b0)
            report_mismatch("reset_state", "mem_wr", 16'd0, 16'(mem_wr));
        if (a_out !== 8'h00)
            report_mismatch("reset_state", "a_out", 16'd0, 16'(a_out));
        if (flags_out !== 8'h00)
            report_mismatch("reset_state", "flags_out", 16'd0, 16'(flags_out));
        close_test("reset_state");
    endtask

    // ******************************************************************
    // One instruction run with timing, result and flag checks
    // ******************************************************************

    task automatic run_one(input byte_t op, input int idx);
        string  name;
        addr_t  hl;
        byte_t  a0;
        byte_t  m0;
        byte_t  exp_a;
        byte_t  exp_m;
        flags_t exp_f;
        logic   noisy;
        int     cyc;
        int     rd_n;
        int     wr_n;

        name  = $sformatf("%s_%0d", op[3] ? "rld" : "rrd", idx);
        hl    = 16'(take_bits(16));
        a0    = 8'(take_bits(8));
        m0    = 8'(take_bits(8));
        noisy = 1'(take_bits(1));
        repeat (int'(take_bits(2))) @(negedge clk);   // Idle gap

        @(negedge clk);
        hl_addr      = hl;
        a_load       = 1'b1;
        a_load_value = a0;
        load_req     = 1'b1;
        load_addr    = hl[7:0];
        load_data    = m0;
        @(negedge clk);
        a_load   = 1'b0;
        load_req = 1'b0;
        start    = 1'b1;
        opcode   = op;

        cyc  = 0;
        rd_n = 0;
        wr_n = 0;
        while (!done && cyc < 3 * DONE_CYCLE) begin
            @(negedge clk);
            cyc++;
            start  = 1'b0;
            a_load = 1'b0;
            if (mem_rd)
                rd_n++;
            if (mem_wr)
                wr_n++;
            if (mem_rd && mem_wr) begin
                $display("test %s: mem_rd and mem_wr high in the same cycle", name);
                test_errors++;
            end
            if ((mem_rd || mem_wr) && mem_addr !== hl)
                report_mismatch(name, "mem_addr", hl, mem_addr);
            if (noisy && cyc == 7) begin           // Must be ignored while busy
                start        = 1'b1;
                opcode       = op ^ 8'h08;
                a_load       = 1'b1;
                a_load_value = ~a0;
            end
        end

        if (!done) begin
            $display("test %s: done never came after the start pulse", name);
            test_errors++;
        end else if (cyc != DONE_CYCLE) begin
            report_mismatch(name, "done_cycle", 16'(DONE_CYCLE), 16'(cyc));
        end
        if (rd_n != 3)
            report_mismatch(name, "mem_rd_cycles", 16'd3, 16'(rd_n));
        if (wr_n != 3)
            report_mismatch(name, "mem_wr_cycles", 16'd3, 16'(wr_n));

        if (op[3]) begin
            exp_a = {a0[7:4], m0[7:4]};
            exp_m = {m0[3:0], a0[3:0]};
        end else begin
            exp_a = {a0[7:4], m0[3:0]};
            exp_m = {a0[3:0], m0[7:4]};
        end
        exp_f          = model_flags;                // C and unused bits held
        exp_f[FLAG_S]  = exp_a[7];
        exp_f[FLAG_Z]  = (exp_a == 8'h00);
        exp_f[FLAG_PV] = even_parity(exp_a);
        exp_f[FLAG_H]  = 1'b0;
        exp_f[FLAG_N]  = 1'b0;
        model_flags    = exp_f;

        if (a_out !== exp_a)
            report_mismatch(name, "a_out", 16'(exp_a), 16'(a_out));
        if (mem[hl[7:0]] !== exp_m)
            report_mismatch(name, "mem_byte", 16'(exp_m), 16'(mem[hl[7:0]]));
        if (flags_out !== exp_f)
            report_mismatch(name, "flags_out", 16'(exp_f), 16'(flags_out));
        close_test(name);
    endtask

    initial begin
        int   n_rrd;
        int   n_rld;
        logic pick_rld;

        arst_n       = 1'b0;
        start        = 1'b0;
        opcode       = 8'h00;
        hl_addr      = 16'h0000;
        a_load       = 1'b0;
        a_load_value = 8'h00;
        load_req     = 1'b0;
        load_addr    = 8'h00;
        load_data    = 8'h00;
        model_flags  = '0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        n_rrd        = 0;
        n_rld        = 0;

        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_reset();

        while (n_rrd + n_rld < 2 * RUNS_PER_OP) begin
            pick_rld = 1'(take_bits(1));
            if (n_rld == RUNS_PER_OP)
                pick_rld = 1'b0;
            else if (n_rrd == RUNS_PER_OP)
                pick_rld = 1'b1;
            if (pick_rld) begin
                run_one(8'h6F, n_rld);
                n_rld++;
            end else begin
                run_one(8'h67, n_rrd);
                n_rrd++;
            end
        end

        $display("tests %0d passed %0d failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCH_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verilog.f
rxd_pkg.sv
rxd_ctrl_if.sv
rxd_seq_fsm.sv
rxd_step_counter.sv
rxd_step_decoder.sv
rxd_mem_port.sv
rxd_nibble_alu.sv
rxd_top.sv
rxd_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RRD/RLD testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rxd_tb -f verilog.f -o rxd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rxd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
